// ==== m0_core.f ====
cpu_pkg.sv
pipe_ifs.sv
fetch_unit.sv
thumb_decoder.sv
reg_file.sv
hazard_unit.sv
execute_stage.sv
writeback_stage.sv
m0_core.sv
clk_gen.sv
m0_core_chk.sv
tb_m0_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_m0_core -f m0_core.f
out=$(./obj_dir/Vtb_m0_core)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qxF -- '** PASS **'; then
    exit 0
else
    exit 1
fi

// ==== tb_m0_core.sv ====
module tb_m0_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_PROG      = 64;                            // Random part of the program
    localparam int N_TAIL      = 8;                             // Register dump stores
    localparam int CYCLE_LIMIT = 4 * (N_PROG + N_TAIL) + 50;
    localparam int IMEM_WORDS  = 128;
    localparam int DMEM_WORDS  = 64;
    localparam logic [15:0] NOP  = 16'h0000;                    // Matches no kept format
    localparam logic [31:0] SEED = 32'h89ac;

    logic                        CLK;
    logic                        RESET_N;
    logic                        IREQ;
    logic [cpu_pkg::XLEN-1:0]    IADDR;
    logic [cpu_pkg::INSTR_W-1:0] INSTR;
    logic                        DREQ;
    logic [cpu_pkg::XLEN-1:0]    DADDR;
    logic                        DRW;
    logic [cpu_pkg::XLEN-1:0]    DIN;
    logic [cpu_pkg::XLEN-1:0]    DOUT;

    logic [15:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] model_regs [8];
    logic [31:0] model_dmem [DMEM_WORDS];
    logic [31:0] reg_snap [8];       // Model registers before the dump
    logic [3:0]  op_codes [9];       // Kept ALU op fields
    logic [15:0] prog [$];
    logic [31:0] exp_addr [$];       // Model stores in program order
    logic [31:0] exp_data [$];
    logic [31:0] seen_data [$];      // DOUT of every store seen
    int          tail_start;
    int          first_mem;          // Index of the first LDR or STR
    int          value_errors = 0;
    int          other_errors = 0;   // Timeout, extra stores
    int          cycles = 0;
    int          post_reset = 0;     // Negedges since reset release

    clk_gen clk_gen_inst (.CLK(CLK), .RESET_N(RESET_N));

    m0_core m0_core_inst (
        .CLK(CLK), .RESET_N(RESET_N), .IREQ(IREQ), .IADDR(IADDR), .INSTR(INSTR),
        .DREQ(DREQ), .DADDR(DADDR), .DRW(DRW), .DIN(DIN), .DOUT(DOUT)
    );

    // Both memories answer in the same cycle
    assign INSTR = (IADDR < 32'(2 * IMEM_WORDS)) ? imem[IADDR[7:1]] : NOP;
    assign DIN   = dmem[DADDR[7:2]];   // Word index wraps in 64 words

    always @(posedge CLK) begin
        if (DREQ && DRW) begin
            dmem[DADDR[7:2]] <= DOUT;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            value_errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [15:0] alu_instr(input logic [3:0] op, input logic [2:0] rm,
                                              input logic [2:0] rdn);
        return {cpu_pkg::ALU_FMT, op, rm, rdn};
    endfunction

    function automatic logic [15:0] addsub_instr(input logic sub, input logic [2:0] imm3,
                                                 input logic [2:0] rn, input logic [2:0] rd);
        return {cpu_pkg::ADDSUB_IMM_FMT, sub, imm3, rn, rd};
    endfunction

    function automatic logic [15:0] mov_instr(input logic [2:0] rd, input logic [7:0] imm8);
        return {cpu_pkg::MOV_IMM_FMT, rd, imm8};
    endfunction

    function automatic logic [15:0] mem_instr(input logic load, input logic [4:0] imm5,
                                              input logic [2:0] rn, input logic [2:0] rt);
        return {load ? cpu_pkg::LDR_FMT : cpu_pkg::STR_FMT, imm5, rn, rt};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'h5a00_0000 ^ (32'(idx) * 32'h0001_0103);   // Every address bit counts
    endfunction

    task automatic build_program();
        int         kind;
        int         sel;
        logic [2:0] ra;
        logic [2:0] rb;
        logic [2:0] rd;
        logic [7:0] base_off;
        while (prog.size() < N_PROG) begin
            kind     = $urandom_range(0, 7);
            sel      = $urandom_range(0, 8);
            ra       = 3'($urandom_range(0, 7));
            rb       = 3'($urandom_range(0, 7));
            rd       = 3'($urandom_range(0, 7));
            base_off = {1'b0, 5'($urandom_range(0, 31)), 2'b00};   // Base under word 32
            case (kind)
                0, 1, 2: prog.push_back(alu_instr(op_codes[sel], rb, rd));
                3:       prog.push_back(addsub_instr(1'($urandom), 3'($urandom), rb, rd));
                4:       prog.push_back(mov_instr(rd, 8'($urandom)));
                5: begin
                    prog.push_back(mov_instr(ra, base_off));
                    prog.push_back(mem_instr(1'b0, 5'($urandom), ra, rd));
                end
                6: begin
                    prog.push_back(mov_instr(ra, base_off));
                    prog.push_back(mem_instr(1'b1, 5'($urandom), ra, rd));
                    prog.push_back(addsub_instr(1'b0, 3'($urandom), rd, rb));   // Load-use
                    prog.push_back(mem_instr(1'b0, 5'($urandom), ra, rb));     // Result out
                end
                default: prog.push_back({5'b11100, 11'($urandom)});   // Branch, no-op here
            endcase
        end
        tail_start = prog.size();
        prog.push_back(mem_instr(1'b0, 5'd0, 3'd7, 3'd7));   // r7 before it is reused
        prog.push_back(mov_instr(3'd7, 8'd128));             // Dump area at word 32
        for (int i = 0; i < 7; i++) begin
            prog.push_back(mem_instr(1'b0, 5'(i), 3'd7, 3'(i)));
        end
    endtask

    // Sequential instruction-set model
    task automatic model_step(input logic [15:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        if (ins[15:10] == cpu_pkg::ALU_FMT) begin
            a = model_regs[ins[2:0]];
            b = model_regs[ins[5:3]];
            case (ins[9:6])
                cpu_pkg::ALU_AND: model_regs[ins[2:0]] = a & b;
                cpu_pkg::ALU_EOR: model_regs[ins[2:0]] = a ^ b;
                cpu_pkg::ALU_LSL: model_regs[ins[2:0]] = a << b[4:0];
                cpu_pkg::ALU_LSR: model_regs[ins[2:0]] = a >> b[4:0];
                cpu_pkg::ALU_ADD: model_regs[ins[2:0]] = a + b;
                cpu_pkg::ALU_SUB: model_regs[ins[2:0]] = a - b;
                cpu_pkg::ALU_ORR: model_regs[ins[2:0]] = a | b;
                cpu_pkg::ALU_MUL: model_regs[ins[2:0]] = a * b;
                cpu_pkg::ALU_MVN: model_regs[ins[2:0]] = ~b;
                default: ;   // Other op fields leave state alone
            endcase
        end else if (ins[15:10] == cpu_pkg::ADDSUB_IMM_FMT) begin
            a = model_regs[ins[5:3]];
            b = {29'd0, ins[8:6]};
            model_regs[ins[2:0]] = ins[9] ? a - b : a + b;
        end else if (ins[15:11] == cpu_pkg::MOV_IMM_FMT) begin
            model_regs[ins[10:8]] = {24'd0, ins[7:0]};
        end else if (ins[15:11] == cpu_pkg::STR_FMT) begin
            addr = model_regs[ins[5:3]] + {25'd0, ins[10:6], 2'b00};
            exp_addr.push_back(addr);
            exp_data.push_back(model_regs[ins[2:0]]);
            model_dmem[addr[7:2]] = model_regs[ins[2:0]];
        end else if (ins[15:11] == cpu_pkg::LDR_FMT) begin
            addr = model_regs[ins[5:3]] + {25'd0, ins[10:6], 2'b00};
            model_regs[ins[2:0]] = model_dmem[addr[7:2]];
        end
    endtask

    // Store monitor, outputs settled at the falling edge
    always @(negedge CLK) begin
        if (RESET_N) begin
            if (post_reset == 0) begin
                check_value(IADDR, cpu_pkg::RESET_PC, "IADDR after reset");
            end
            check_value(32'(IREQ), 32'd1, "IREQ out of reset");
            // Instruction k sits in EX/MEM at negedge k+3, no stall can come earlier
            if (post_reset < first_mem + 3) begin
                check_value(32'(DREQ), 32'd0, "DREQ before the first memory access");
            end
            post_reset++;
            if (DREQ && DRW) begin
                if (seen_data.size() < exp_addr.size()) begin
                    check_value(DADDR, exp_addr[seen_data.size()], "store address");
                    check_value(DOUT, exp_data[seen_data.size()], "store data");
                end else begin
                    other_errors++;
                    $display("A store appeared after all expected stores at %0t", $time);
                end
                seen_data.push_back(DOUT);
            end
        end
    end

    initial begin
        int base;
        void'($urandom(SEED));
        op_codes = '{cpu_pkg::ALU_AND, cpu_pkg::ALU_EOR, cpu_pkg::ALU_LSL,
                     cpu_pkg::ALU_LSR, cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB,
                     cpu_pkg::ALU_ORR, cpu_pkg::ALU_MUL, cpu_pkg::ALU_MVN};
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP;   // Past the program
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]       = fill_word(i);
            model_dmem[i] = fill_word(i);
        end
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i];
        end

        // Expected stores, starting from zeroed registers
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        first_mem = prog.size();
        for (int i = 0; i < prog.size(); i++) begin
            if (i == tail_start) begin
                reg_snap = model_regs;
            end
            if (first_mem == prog.size() &&
                (prog[i][15:11] == cpu_pkg::STR_FMT || prog[i][15:11] == cpu_pkg::LDR_FMT)) begin
                first_mem = i;
            end
            model_step(prog[i]);
        end

        @(negedge CLK);   // Inside reset
        check_value(IADDR, cpu_pkg::RESET_PC, "IADDR in reset");
        check_value(32'(DREQ), 32'd0, "DREQ in reset");

        wait (RESET_N);
        while (seen_data.size() < exp_addr.size() && cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            other_errors++;
            $display("The run timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, seen_data.size(), exp_addr.size());
        end

        check_value(32'(seen_data.size()), 32'(exp_addr.size()), "store count");
        if (seen_data.size() >= N_TAIL) begin
            base = seen_data.size() - N_TAIL;
            check_value(seen_data[base], reg_snap[7], "dump of r7");
            for (int i = 0; i < 7; i++) begin
                check_value(seen_data[base + 1 + i], reg_snap[i], $sformatf("dump of r%0d", i));
            end
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== m0_core_chk.sv ====
module m0_core_chk (
    input logic                     CLK,
    input logic                     RESET_N,
    input logic                     DREQ,
    input logic [cpu_pkg::XLEN-1:0] IADDR,
    input logic                     stall
);
    timeunit 1ns;
    timeprecision 1ps;

    // No data access while held in reset
    dreq_in_reset: assert property (@(posedge CLK) !RESET_N |-> !DREQ)
        else $error("DREQ high while RESET_N is low");

    // PC holds on a stall, otherwise one step
    pc_advance: assert property (@(posedge CLK) disable iff (!RESET_N)
        IADDR == $past(IADDR) || IADDR == $past(IADDR) + cpu_pkg::PC_STEP)
        else $error("IADDR moved by something other than zero or one step");

    // Bubble clears the load from ID/EX
    single_stall: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(stall && $past(stall)))
        else $error("stall held for two cycles in a row");

endmodule

bind m0_core m0_core_chk m0_core_chk_inst (
    .CLK(CLK), .RESET_N(RESET_N), .DREQ(DREQ), .IADDR(IADDR), .stall(stall)
);

// ==== clk_gen.sv ====
module clk_gen (
    output logic CLK,
    output logic RESET_N
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    initial begin
        RESET_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET_N <= 1'b1;   // Released on a rising edge
    end

endmodule

// ==== m0_core.sv ====
module m0_core (
    input  logic                        CLK,
    input  logic                        RESET_N,
    output logic                        IREQ,
    output logic [cpu_pkg::XLEN-1:0]    IADDR,
    input  logic [cpu_pkg::INSTR_W-1:0] INSTR,
    output logic                        DREQ,
    output logic [cpu_pkg::XLEN-1:0]    DADDR,
    output logic                        DRW,     // 1 for store
    input  logic [cpu_pkg::XLEN-1:0]    DIN,     // Combinational read data
    output logic [cpu_pkg::XLEN-1:0]    DOUT
);
    logic                        stall;      // Load-use hold
    logic [cpu_pkg::INSTR_W-1:0] if_instr;   // IF/ID
    logic [cpu_pkg::REG_AW-1:0]  rd_a_addr;
    logic [cpu_pkg::REG_AW-1:0]  rd_b_addr;
    logic [cpu_pkg::XLEN-1:0]    rd_a_data;
    logic [cpu_pkg::XLEN-1:0]    rd_b_data;
    cpu_pkg::fwd_sel_e           fwd_a;
    cpu_pkg::fwd_sel_e           fwd_b;
    logic                        wb_we;      // Writeback port
    logic [cpu_pkg::REG_AW-1:0]  wb_addr;
    logic [cpu_pkg::XLEN-1:0]    wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();

    fetch_unit fetch_unit_inst (
        .CLK(CLK), .RESET_N(RESET_N), .stall(stall), .INSTR(INSTR),
        .IADDR(IADDR), .IREQ(IREQ), .if_instr(if_instr)
    );

    thumb_decoder thumb_decoder_inst (
        .CLK(CLK), .RESET_N(RESET_N), .stall(stall), .if_instr(if_instr),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
        .rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr), .id_ex(id_ex.producer)
    );

    reg_file reg_file_inst (
        .CLK(CLK), .RESET_N(RESET_N), .rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data)
    );

    hazard_unit hazard_unit_inst (
        .rd_a_addr(rd_a_addr), .rd_b_addr(rd_b_addr),
        .id_ex(id_ex.consumer), .ex_mem(ex_mem.consumer),
        .wb_we(wb_we), .wb_addr(wb_addr),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage execute_stage_inst (
        .CLK(CLK), .RESET_N(RESET_N), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .wb_data(wb_data), .id_ex(id_ex.consumer), .ex_mem(ex_mem.producer)
    );

    writeback_stage writeback_stage_inst (
        .CLK(CLK), .RESET_N(RESET_N), .DIN(DIN), .ex_mem(ex_mem.consumer),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    // Data port straight off EX/MEM
    assign DREQ  = ex_mem.mem_re | ex_mem.mem_we;
    assign DRW   = ex_mem.mem_we;
    assign DADDR = ex_mem.result;
    assign DOUT  = ex_mem.store_data;

endmodule

// ==== writeback_stage.sv ====
module writeback_stage (
    input  logic                       CLK,
    input  logic                       RESET_N,
    input  logic [cpu_pkg::XLEN-1:0]   DIN,
    ex_mem_if.consumer                 ex_mem,
    output logic                       wb_we,
    output logic [cpu_pkg::REG_AW-1:0] wb_addr,
    output logic [cpu_pkg::XLEN-1:0]   wb_data
);
    logic [cpu_pkg::XLEN-1:0] load_q;     // Captured DIN
    logic [cpu_pkg::XLEN-1:0] result_q;
    logic                     is_load_q;

    // MEM/WB control
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            wb_we     <= 1'b0;
            is_load_q <= 1'b0;
        end else begin
            wb_we     <= ex_mem.reg_we;
            is_load_q <= ex_mem.mem_re;
        end
    end

    always_ff @(posedge CLK) begin
        load_q   <= DIN;
        result_q <= ex_mem.result;
        wb_addr  <= ex_mem.dest;
    end

    assign wb_data = is_load_q ? load_q : result_q;   // Loaded word or ALU result

endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic                     CLK,
    input  logic                     RESET_N,
    input  cpu_pkg::fwd_sel_e        fwd_a,
    input  cpu_pkg::fwd_sel_e        fwd_b,
    input  logic [cpu_pkg::XLEN-1:0] wb_data,
    id_ex_if.consumer                id_ex,
    ex_mem_if.producer               ex_mem
);
    logic [cpu_pkg::XLEN-1:0] op_a;
    logic [cpu_pkg::XLEN-1:0] op_b_reg;   // Forwarded register b
    logic [cpu_pkg::XLEN-1:0] op_b;       // ALU input b
    logic [cpu_pkg::XLEN-1:0] alu_y;

    function automatic logic [cpu_pkg::XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_e        sel,
        input logic [cpu_pkg::XLEN-1:0] stage_val,
        input logic [cpu_pkg::XLEN-1:0] mem_val,
        input logic [cpu_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return stage_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(fwd_a, id_ex.a_val, ex_mem.result, wb_data);
    assign op_b_reg = fwd_mux(fwd_b, id_ex.b_val, ex_mem.result, wb_data);
    assign op_b     = id_ex.use_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::ALU_ADD:    alu_y = op_a + op_b;
            cpu_pkg::ALU_SUB:    alu_y = op_a - op_b;
            cpu_pkg::ALU_AND:    alu_y = op_a & op_b;
            cpu_pkg::ALU_ORR:    alu_y = op_a | op_b;
            cpu_pkg::ALU_EOR:    alu_y = op_a ^ op_b;
            cpu_pkg::ALU_MVN:    alu_y = ~op_b;
            cpu_pkg::ALU_MUL:    alu_y = op_a * op_b;        // Low word only
            cpu_pkg::ALU_LSL:    alu_y = op_a << op_b[4:0];  // Amount mod 32
            cpu_pkg::ALU_LSR:    alu_y = op_a >> op_b[4:0];
            cpu_pkg::ALU_PASS_B: alu_y = op_b;               // MOV
            default:             alu_y = '0;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem.reg_we <= 1'b0;
            ex_mem.mem_re <= 1'b0;
            ex_mem.mem_we <= 1'b0;
        end else begin
            ex_mem.reg_we <= id_ex.reg_we;
            ex_mem.mem_re <= id_ex.mem_re;
            ex_mem.mem_we <= id_ex.mem_we;
        end
    end

    // EX/MEM payload
    always_ff @(posedge CLK) begin
        ex_mem.result     <= alu_y;
        ex_mem.store_data <= op_b_reg;   // STR data with forwarding
        ex_mem.dest       <= id_ex.dest;
    end

endmodule

// ==== hazard_unit.sv ====
module hazard_unit (
    input  logic [cpu_pkg::REG_AW-1:0] rd_a_addr,   // Sources in decode
    input  logic [cpu_pkg::REG_AW-1:0] rd_b_addr,
    id_ex_if.consumer                  id_ex,
    ex_mem_if.consumer                 ex_mem,
    input  logic                       wb_we,
    input  logic [cpu_pkg::REG_AW-1:0] wb_addr,
    output logic                       stall,
    output cpu_pkg::fwd_sel_e          fwd_a,
    output cpu_pkg::fwd_sel_e          fwd_b
);
    logic mem_fwd_ok;   // EX/MEM holds an ALU result for a register

    // Nearer stage wins
    function automatic cpu_pkg::fwd_sel_e pick_fwd(
        input logic mem_hit,
        input logic wb_hit
    );
        if (mem_hit) begin
            return cpu_pkg::FWD_MEM;
        end else if (wb_hit) begin
            return cpu_pkg::FWD_WB;
        end
        return cpu_pkg::FWD_NONE;
    endfunction

    assign mem_fwd_ok = ex_mem.reg_we && !ex_mem.mem_re;   // Load data not there yet

    assign fwd_a = pick_fwd(mem_fwd_ok && ex_mem.dest == id_ex.a_reg,
                            wb_we && wb_addr == id_ex.a_reg);
    assign fwd_b = pick_fwd(mem_fwd_ok && ex_mem.dest == id_ex.b_reg,
                            wb_we && wb_addr == id_ex.b_reg);

    // Load in EX feeding the instruction in decode
    assign stall = id_ex.mem_re &&
                   (id_ex.dest == rd_a_addr || id_ex.dest == rd_b_addr);

endmodule

// ==== reg_file.sv ====
module reg_file (
    input  logic                       CLK,
    input  logic                       RESET_N,
    input  logic [cpu_pkg::REG_AW-1:0] rd_a_addr,
    input  logic [cpu_pkg::REG_AW-1:0] rd_b_addr,
    input  logic                       wb_we,
    input  logic [cpu_pkg::REG_AW-1:0] wb_addr,
    input  logic [cpu_pkg::XLEN-1:0]   wb_data,
    output logic [cpu_pkg::XLEN-1:0]   rd_a_data,
    output logic [cpu_pkg::XLEN-1:0]   rd_b_data
);
    logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Write-before-read bypass
    assign rd_a_data = (wb_we && wb_addr == rd_a_addr) ? wb_data : regs[rd_a_addr];
    assign rd_b_data = (wb_we && wb_addr == rd_b_addr) ? wb_data : regs[rd_b_addr];

endmodule

// ==== thumb_decoder.sv ====
module thumb_decoder (
    input  logic                        CLK,
    input  logic                        RESET_N,
    input  logic                        stall,
    input  logic [cpu_pkg::INSTR_W-1:0] if_instr,
    input  logic [cpu_pkg::XLEN-1:0]    rd_a_data,
    input  logic [cpu_pkg::XLEN-1:0]    rd_b_data,
    output logic [cpu_pkg::REG_AW-1:0]  rd_a_addr,
    output logic [cpu_pkg::REG_AW-1:0]  rd_b_addr,
    id_ex_if.producer                   id_ex
);
    logic [cpu_pkg::REG_AW-1:0] dest;
    logic [cpu_pkg::XLEN-1:0]   imm;
    logic                       use_imm;
    cpu_pkg::alu_op_e           alu_op;
    logic                       reg_we;
    logic                       mem_re;
    logic                       mem_we;

    always_comb begin
        rd_a_addr = if_instr[2:0];   // Rdn in ALU format
        rd_b_addr = if_instr[5:3];   // Rm or Rn
        dest      = if_instr[2:0];
        imm       = '0;
        use_imm   = 1'b0;
        alu_op    = cpu_pkg::ALU_ADD;
        reg_we    = 1'b0;
        mem_re    = 1'b0;
        mem_we    = 1'b0;

        if (if_instr[15:10] == cpu_pkg::ALU_FMT) begin
            reg_we = 1'b1;
            case (if_instr[9:6])
                cpu_pkg::ALU_AND, cpu_pkg::ALU_EOR, cpu_pkg::ALU_LSL,
                cpu_pkg::ALU_LSR, cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB,
                cpu_pkg::ALU_ORR, cpu_pkg::ALU_MUL, cpu_pkg::ALU_MVN:
                    alu_op = cpu_pkg::alu_op_e'(if_instr[9:6]);
                default: reg_we = 1'b0;   // Unsupported op
            endcase
        end else if (if_instr[15:10] == cpu_pkg::ADDSUB_IMM_FMT) begin
            rd_a_addr = if_instr[5:3];          // Rn
            imm[2:0]  = if_instr[8:6];          // imm3
            use_imm   = 1'b1;
            alu_op    = if_instr[9] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            reg_we    = 1'b1;
        end else if (if_instr[15:11] == cpu_pkg::MOV_IMM_FMT) begin
            dest     = if_instr[10:8];
            imm[7:0] = if_instr[7:0];
            use_imm  = 1'b1;
            alu_op   = cpu_pkg::ALU_PASS_B;
            reg_we   = 1'b1;
        end else if (if_instr[15:11] == cpu_pkg::STR_FMT ||
                     if_instr[15:11] == cpu_pkg::LDR_FMT) begin
            rd_a_addr = if_instr[5:3];          // Base
            imm[6:2]  = if_instr[10:6];         // Word offset
            use_imm   = 1'b1;
            if (if_instr[11]) begin
                reg_we = 1'b1;
                mem_re = 1'b1;
            end else begin
                rd_b_addr = if_instr[2:0];      // Store data reg
                mem_we    = 1'b1;
            end
        end
    end

    // ID/EX control, bubble on stall
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex.reg_we <= 1'b0;
            id_ex.mem_re <= 1'b0;
            id_ex.mem_we <= 1'b0;
        end else begin
            id_ex.reg_we <= reg_we && !stall;
            id_ex.mem_re <= mem_re && !stall;
            id_ex.mem_we <= mem_we && !stall;
        end
    end

    // ID/EX payload
    always_ff @(posedge CLK) begin
        id_ex.a_val   <= rd_a_data;
        id_ex.b_val   <= rd_b_data;
        id_ex.imm     <= imm;
        id_ex.a_reg   <= rd_a_addr;
        id_ex.b_reg   <= rd_b_addr;
        id_ex.dest    <= dest;
        id_ex.use_imm <= use_imm;
        id_ex.alu_op  <= alu_op;
    end

endmodule

// ==== fetch_unit.sv ====
module fetch_unit (
    input  logic                        CLK,
    input  logic                        RESET_N,
    input  logic                        stall,
    input  logic [cpu_pkg::INSTR_W-1:0] INSTR,
    output logic [cpu_pkg::XLEN-1:0]    IADDR,
    output logic                        IREQ,
    output logic [cpu_pkg::INSTR_W-1:0] if_instr
);
    logic [cpu_pkg::XLEN-1:0] pc;

    assign IADDR = pc;
    assign IREQ  = 1'b1;   // Fetch every cycle

    // PC and IF/ID move together
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc       <= cpu_pkg::RESET_PC;
            if_instr <= '0;   // Decodes as no-op
        end else if (!stall) begin
            pc       <= pc + cpu_pkg::PC_STEP;
            if_instr <= INSTR;
        end
        // Stall holds both
    end

endmodule

// ==== pipe_ifs.sv ====
interface id_ex_if;
    logic [cpu_pkg::XLEN-1:0]   a_val;    // Port a value at decode
    logic [cpu_pkg::XLEN-1:0]   b_val;    // Port b value, store data for STR
    logic [cpu_pkg::XLEN-1:0]   imm;      // Zero extended
    logic [cpu_pkg::REG_AW-1:0] a_reg;
    logic [cpu_pkg::REG_AW-1:0] b_reg;
    logic [cpu_pkg::REG_AW-1:0] dest;
    logic                       use_imm;  // ALU b from imm
    cpu_pkg::alu_op_e           alu_op;
    logic                       reg_we;
    logic                       mem_re;   // Load
    logic                       mem_we;   // Store

    modport producer (
        output a_val, b_val, imm, a_reg, b_reg, dest,
        output use_imm, alu_op, reg_we, mem_re, mem_we
    );
    modport consumer (
        input a_val, b_val, imm, a_reg, b_reg, dest,
        input use_imm, alu_op, reg_we, mem_re, mem_we
    );
endinterface

interface ex_mem_if;
    logic [cpu_pkg::XLEN-1:0]   result;      // ALU result or data address
    logic [cpu_pkg::XLEN-1:0]   store_data;  // Forwarded b operand
    logic [cpu_pkg::REG_AW-1:0] dest;
    logic                       reg_we;
    logic                       mem_re;
    logic                       mem_we;

    modport producer (output result, store_data, dest, reg_we, mem_re, mem_we);
    modport consumer (input result, store_data, dest, reg_we, mem_re, mem_we);
endinterface

// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN     = 32;   // Data and address width
    localparam int INSTR_W  = 16;   // Thumb halfword
    localparam int REG_AW   = 3;    // Low registers only
    localparam int NUM_REGS = 8;    // r0 to r7
    localparam int PC_STEP  = 2;    // Bytes per instruction

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Enum values double as the op field of the register ALU format
    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_EOR    = 4'b0001,
        ALU_LSL    = 4'b0010,
        ALU_LSR    = 4'b0011,
        ALU_ADD    = 4'b0100,
        ALU_SUB    = 4'b0101,
        ALU_PASS_B = 4'b0110,   // Internal only, used by MOV
        ALU_MUL    = 4'b1000,
        ALU_ORR    = 4'b1100,
        ALU_MVN    = 4'b1111
    } alu_op_e;

    // Format patterns on the top instruction bits
    localparam logic [5:0] ALU_FMT        = 6'b010000;  // instr[15:10]
    localparam logic [5:0] ADDSUB_IMM_FMT = 6'b000111;  // instr[15:10]
    localparam logic [4:0] MOV_IMM_FMT    = 5'b00100;   // instr[15:11]
    localparam logic [4:0] STR_FMT        = 5'b01100;   // instr[15:11]
    localparam logic [4:0] LDR_FMT        = 5'b01101;   // instr[15:11]

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,   // Value read in decode
        FWD_MEM  = 2'd1,   // EX/MEM result
        FWD_WB   = 2'd2    // Writeback data
    } fwd_sel_e;

endpackage
